//--- list.f
design/shader_pkg.sv
design/shader_op_if.sv
design/shader_regfile.sv
design/shader_decode.sv
design/shader_operands.sv
design/shader_alu.sv
design/shader_writeback.sv
design/shader_core.sv
dv/shader_clk_gen.sv
dv/shader_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the shader testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	-f list.f --top-module shader_tb -o shader_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/shader_sim)
status=$?
echo "$out"

if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "test passed"; then
	exit 0
fi
exit 1

//--- dv/shader_tb.sv
`timescale 1ns/1ps
`default_nettype none

module shader_tb;

	localparam int IDLE_CYCLES = 5;
	localparam int OUT_BITS = 8 + 2 + 4 + 1 + shader_pkg::LANES * shader_pkg::WORD_BITS;

	logic clk;
	logic arst_n;
	logic instr_valid;
	shader_pkg::instr_word instr;
	shader_pkg::group_id group;
	shader_pkg::lane_word result;
	logic result_valid;
	shader_pkg::group_id result_group;
	shader_pkg::reg_num result_dst;
	logic result_scalar;

	// table of tests and expected outcomes.
	string tbl_name [$];
	shader_pkg::instr_word tbl_instr [$];
	shader_pkg::group_id tbl_group [$];
	int tbl_gap [$];
	shader_pkg::lane_word tbl_expect [$];
	shader_pkg::reg_num tbl_dst [$];
	logic tbl_scalar [$];

	int pend_idx [$];
	int pend_issue [$];

	// model register state.
	shader_pkg::word sgpr_m [4][16];
	shader_pkg::word vgpr_m [4][16][shader_pkg::LANES];

	logic [31:0] lcg_state;
	int cycle = 0;
	int run_cycles = 0;
	int timeout_limit = 0;
	int n_tests = 0;
	int checked = 0;
	int errors = 0;

	shader_clk_gen #(.PERIOD_NS(4), .RESET_CYCLES(10)) clk_gen (.clk, .arst_n);

	shader_core dut (
		.clk,
		.arst_n,
		.instr_valid,
		.instr,
		.group,
		.result,
		.result_valid,
		.result_group,
		.result_dst,
		.result_scalar
	);

	// ====================
	// stimulus helpers
	function automatic logic [15:0] next_imm();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state[31:16];
	endfunction

	function automatic shader_pkg::instr_word encode_reg(
		input shader_pkg::opcode op,
		input logic dst_s,
		input shader_pkg::reg_num dst,
		input logic a_s,
		input shader_pkg::reg_num a,
		input logic b_s,
		input logic b_c,
		input logic rev,
		input shader_pkg::reg_num b
	);
		shader_pkg::instr_word w;
		w = '0;
		w.as_reg.opcode = op;
		w.as_reg.dst_scalar = dst_s;
		w.as_reg.dst = dst;
		w.as_reg.a_scalar = a_s;
		w.as_reg.a = a;
		w.as_reg.b_scalar = b_s;
		w.as_reg.b_is_const = b_c;
		w.as_reg.scalar_rev = rev;
		w.as_reg.b = b;
		return w;
	endfunction

	function automatic shader_pkg::instr_word encode_imm(
		input shader_pkg::opcode op,
		input logic dst_s,
		input shader_pkg::reg_num dst,
		input logic a_s,
		input shader_pkg::reg_num a,
		input logic [15:0] imm
	);
		shader_pkg::instr_word w;
		w = '0;
		w.as_imm.imm_form = 1'b1;
		w.as_imm.opcode = op;
		w.as_imm.dst_scalar = dst_s;
		w.as_imm.dst = dst;
		w.as_imm.a_scalar = a_s;
		w.as_imm.a = a;
		w.as_imm.imm = imm;
		return w;
	endfunction

	// ====================
	// reference model
	function automatic shader_pkg::word const_value(input shader_pkg::reg_num idx);
		case (idx)
			4'd0: return 32'hffff_ffff;
			4'd1: return 32'h7fff_ffff;
			4'd2: return 32'h8000_0000;
			4'd3: return 32'h3f80_0000;
			4'd4: return 32'hbf80_0000;
			default: return '0;
		endcase
	endfunction

	task automatic model_step(
		input shader_pkg::instr_word w,
		input shader_pkg::group_id g,
		output shader_pkg::lane_word res,
		output shader_pkg::reg_num dst,
		output logic dst_s
	);
		shader_pkg::opcode op;
		shader_pkg::reg_num a;
		shader_pkg::reg_num b;
		logic a_s;
		logic b_s;
		logic b_c;
		logic b_i;
		logic rev;
		shader_pkg::word imm;
		shader_pkg::word a_val;
		shader_pkg::word b_val;
		shader_pkg::word tmp;
		if (w.as_imm.imm_form) begin
			op = w.as_imm.opcode;
			dst = w.as_imm.dst;
			dst_s = w.as_imm.dst_scalar;
			a = w.as_imm.a;
			a_s = w.as_imm.a_scalar;
			b = '0;
			{b_s, b_c, rev, b_i} = 4'b0001;
			imm = {16'h0, w.as_imm.imm};
		end else begin
			op = w.as_reg.opcode;
			dst = w.as_reg.dst;
			dst_s = w.as_reg.dst_scalar;
			a = w.as_reg.a;
			a_s = w.as_reg.a_scalar;
			b = w.as_reg.b;
			{b_s, b_c, rev, b_i} = {w.as_reg.b_scalar, w.as_reg.b_is_const,
				w.as_reg.scalar_rev, 1'b0};
			imm = '0;
		end
		for (int l = 0; l < shader_pkg::LANES; l++) begin
			a_val = a_s ? sgpr_m[g][a] : vgpr_m[g][a][l];
			if (b_i)
				b_val = imm;
			else if (b_c)
				b_val = const_value(b);
			else if (b_s)
				b_val = sgpr_m[g][b];
			else
				b_val = vgpr_m[g][b][l];
			if (rev && a_s && (b_i || b_c || b_s)) begin // both scalar.
				tmp = a_val;
				a_val = b_val;
				b_val = tmp;
			end
			case (op)
				shader_pkg::OP_ADD:  res[l] = a_val + b_val;
				shader_pkg::OP_SUB:  res[l] = a_val - b_val;
				shader_pkg::OP_AND:  res[l] = a_val & b_val;
				shader_pkg::OP_OR:   res[l] = a_val | b_val;
				shader_pkg::OP_XOR:  res[l] = a_val ^ b_val;
				shader_pkg::OP_MOV:  res[l] = b_val;
				shader_pkg::OP_LANE: res[l] = shader_pkg::word'(l);
				default:             res[l] = '0;
			endcase
		end
		for (int l = 0; l < shader_pkg::LANES; l++) begin
			if (dst_s)
				sgpr_m[g][dst] = res[0];
			else
				vgpr_m[g][dst][l] = res[l];
		end
	endtask

	task automatic add_entry(
		input string name,
		input shader_pkg::group_id g,
		input int gap,
		input shader_pkg::instr_word w
	);
		shader_pkg::lane_word res;
		shader_pkg::reg_num dst;
		logic dst_s;
		model_step(w, g, res, dst, dst_s);
		tbl_name.push_back(name);
		tbl_instr.push_back(w);
		tbl_group.push_back(g);
		tbl_gap.push_back(gap);
		tbl_expect.push_back(res);
		tbl_dst.push_back(dst);
		tbl_scalar.push_back(dst_s);
	endtask

	// gaps of 10 wherever a later entry reads an earlier result.
	task automatic build_table();
		add_entry("lane_v0", 2'd0, 10,
			encode_reg(shader_pkg::OP_LANE, 1'b0, 4'd0, 1'b0, 4'd0, 1'b0, 1'b0, 1'b0, 4'd0));
		add_entry("mov_s1_imm", 2'd0, 1,
			encode_imm(shader_pkg::OP_MOV, 1'b1, 4'd1, 1'b0, 4'd0, next_imm()));
		add_entry("add_v2_imm", 2'd0, 1,
			encode_imm(shader_pkg::OP_ADD, 1'b0, 4'd2, 1'b0, 4'd0, next_imm()));
		add_entry("mov_s3_imm", 2'd0, 10,
			encode_imm(shader_pkg::OP_MOV, 1'b1, 4'd3, 1'b0, 4'd0, next_imm()));
		add_entry("add_s6_imm", 2'd0, 1,
			encode_imm(shader_pkg::OP_ADD, 1'b1, 4'd6, 1'b1, 4'd3, next_imm()));
		add_entry("add_v4", 2'd0, 10,
			encode_reg(shader_pkg::OP_ADD, 1'b0, 4'd4, 1'b0, 4'd0, 1'b0, 1'b0, 1'b0, 4'd2));
		add_entry("sub_v5_wrap", 2'd0, 10,
			encode_reg(shader_pkg::OP_SUB, 1'b0, 4'd5, 1'b0, 4'd0, 1'b0, 1'b0, 1'b0, 4'd2));
		add_entry("and_v6", 2'd0, 1,
			encode_reg(shader_pkg::OP_AND, 1'b0, 4'd6, 1'b0, 4'd2, 1'b0, 1'b0, 1'b0, 4'd4));
		add_entry("or_v7", 2'd0, 1,
			encode_reg(shader_pkg::OP_OR, 1'b0, 4'd7, 1'b0, 4'd2, 1'b0, 1'b0, 1'b0, 4'd0));
		add_entry("xor_v8", 2'd0, 1,
			encode_reg(shader_pkg::OP_XOR, 1'b0, 4'd8, 1'b0, 4'd4, 1'b0, 1'b0, 1'b0, 4'd2));
		add_entry("const_v9", 2'd0, 1,
			encode_reg(shader_pkg::OP_ADD, 1'b0, 4'd9, 1'b0, 4'd0, 1'b0, 1'b1, 1'b0, 4'd1));
		add_entry("rev_sub_s4", 2'd0, 10,
			encode_reg(shader_pkg::OP_SUB, 1'b1, 4'd4, 1'b1, 4'd1, 1'b1, 1'b0, 1'b1, 4'd3));
		add_entry("bcast_s4_v10", 2'd0, 1,
			encode_reg(shader_pkg::OP_ADD, 1'b0, 4'd10, 1'b1, 4'd4, 1'b0, 1'b0, 1'b0, 4'd0));
		add_entry("scalar_dst_s5", 2'd0, 10,
			encode_reg(shader_pkg::OP_ADD, 1'b1, 4'd5, 1'b0, 4'd4, 1'b0, 1'b0, 1'b0, 4'd2));
		add_entry("read_s5_v11", 2'd0, 1,
			encode_reg(shader_pkg::OP_MOV, 1'b0, 4'd11, 1'b0, 4'd0, 1'b1, 1'b0, 1'b0, 4'd5));
		add_entry("g1_mov_v3", 2'd1, 1,
			encode_imm(shader_pkg::OP_MOV, 1'b0, 4'd3, 1'b0, 4'd0, next_imm()));
		add_entry("g2_mov_s0", 2'd2, 1,
			encode_imm(shader_pkg::OP_MOV, 1'b1, 4'd0, 1'b0, 4'd0, next_imm()));
		add_entry("g3_lane_v1", 2'd3, 1,
			encode_reg(shader_pkg::OP_LANE, 1'b0, 4'd1, 1'b0, 4'd0, 1'b0, 1'b0, 1'b0, 4'd0));
		add_entry("g0_mov_v3", 2'd0, 10,
			encode_imm(shader_pkg::OP_MOV, 1'b0, 4'd3, 1'b0, 4'd0, next_imm()));
		add_entry("g1_read_v3", 2'd1, 1,
			encode_reg(shader_pkg::OP_MOV, 1'b0, 4'd12, 1'b0, 4'd0, 1'b0, 1'b0, 1'b0, 4'd3));
		add_entry("const_zero_v14", 2'd0, 1,
			encode_reg(shader_pkg::OP_ADD, 1'b0, 4'd14, 1'b0, 4'd0, 1'b0, 1'b1, 1'b0, 4'd9));
		add_entry("g2_xor_s1_imm", 2'd2, 10,
			encode_imm(shader_pkg::OP_XOR, 1'b1, 4'd1, 1'b1, 4'd0, next_imm()));
	endtask

	// ====================
	// checks
	task automatic check_value(
		input string name,
		input logic [OUT_BITS-1:0] expected,
		input logic [OUT_BITS-1:0] actual
	);
		checked++;
		if (actual !== expected) begin
			errors++;
			$display("Fail %s expected %h actual %h", name, expected, actual);
		end else begin
			$display("Pass %s", name);
		end
	endtask

	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (arst_n)
			run_cycles <= run_cycles + 1;
	end

	// latency, group, dst, scalar flag and lanes in one word.
	always @(negedge clk) begin : monitor
		int idx;
		int issued_at;
		logic [OUT_BITS-1:0] exp_v;
		logic [OUT_BITS-1:0] act_v;
		if (arst_n === 1'b1 && result_valid === 1'b1) begin
			if (pend_idx.size() == 0) begin
				errors++;
				$display("result_valid went high with no instruction in flight");
			end else begin
				idx = pend_idx.pop_front();
				issued_at = pend_issue.pop_front();
				exp_v = {8'(shader_pkg::PIPE_LATENCY), tbl_group[idx], tbl_dst[idx],
					tbl_scalar[idx], tbl_expect[idx]};
				act_v = {8'(cycle + 1 - issued_at), result_group, result_dst,
					result_scalar, result};
				check_value(tbl_name[idx], exp_v, act_v);
			end
		end
	end

	always @(negedge clk) begin
		if (timeout_limit > 0 && run_cycles > timeout_limit) begin
			$display("timeout after %0d cycles, %0d of %0d results seen",
				run_cycles, checked, n_tests);
			$display("test failed");
			$finish;
		end
	end

	// ====================
	// main sequence
	initial begin
		instr_valid = 1'b0;
		instr = '0;
		group = '0;
		lcg_state = 32'd26;
		build_table();
		n_tests = tbl_name.size();
		timeout_limit = IDLE_CYCLES + shader_pkg::PIPE_LATENCY + 20;
		foreach (tbl_gap[i])
			timeout_limit += tbl_gap[i];

		wait (arst_n === 1'b1);
		repeat (IDLE_CYCLES) @(posedge clk); // result_valid must stay low here.
		#1;
		for (int i = 0; i < n_tests; i++) begin
			instr_valid = 1'b1;
			instr = tbl_instr[i];
			group = tbl_group[i];
			pend_idx.push_back(i);
			pend_issue.push_back(cycle + 1); // edge that samples it.
			@(posedge clk);
			#1 instr_valid = 1'b0;
			repeat (tbl_gap[i] - 1) begin
				@(posedge clk);
				#1;
			end
		end

		wait (checked == n_tests);
		repeat (4) @(posedge clk); // catch any stray result.
		$display("results checked %0d of %0d, mismatches and other errors %0d",
			checked, n_tests, errors);
		if (errors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- dv/shader_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module shader_clk_gen #(
	parameter int PERIOD_NS = 4,
	parameter int RESET_CYCLES = 10
) (
	output logic clk,
	output logic arst_n
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

	initial begin
		arst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#1 arst_n = 1'b1; // released just after an edge.
	end

endmodule

`default_nettype wire

//--- design/shader_core.sv
`timescale 1ns/1ps
`default_nettype none

module shader_core (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  instr_valid,
	input  shader_pkg::instr_word instr,
	input  shader_pkg::group_id   group,
	output shader_pkg::lane_word  result,
	output logic                  result_valid,
	output shader_pkg::group_id   result_group,
	output shader_pkg::reg_num    result_dst,
	output logic                  result_scalar
);

	shader_op_if op_bus ();

	shader_pkg::lane_word a_lanes, b_lanes, alu_lanes, wb_data;
	shader_pkg::opcode op_code;
	shader_pkg::group_id op_group, alu_group, wb_group;
	shader_pkg::reg_num op_dst, alu_dst, wb_dst;
	logic op_valid, op_dst_scalar;
	logic alu_valid, alu_dst_scalar;
	logic wb_write, wb_dst_scalar;

	shader_decode decode (
		.clk,
		.arst_n,
		.instr_valid,
		.instr,
		.group,
		.op_out(op_bus.decode)
	);

	shader_operands operands (
		.clk,
		.arst_n,
		.op_in(op_bus.fetch),
		.wb_write,
		.wb_group,
		.wb_dst,
		.wb_dst_scalar,
		.wb_data,
		.a_lanes,
		.b_lanes,
		.op_valid,
		.op_code,
		.op_group,
		.op_dst,
		.op_dst_scalar
	);

	shader_alu alu (
		.clk,
		.arst_n,
		.a_lanes,
		.b_lanes,
		.in_valid(op_valid),
		.in_code(op_code),
		.in_group(op_group),
		.in_dst(op_dst),
		.in_dst_scalar(op_dst_scalar),
		.out_lanes(alu_lanes),
		.out_valid(alu_valid),
		.out_group(alu_group),
		.out_dst(alu_dst),
		.out_dst_scalar(alu_dst_scalar)
	);

	shader_writeback writeback (
		.clk,
		.arst_n,
		.in_lanes(alu_lanes),
		.in_valid(alu_valid),
		.in_group(alu_group),
		.in_dst(alu_dst),
		.in_dst_scalar(alu_dst_scalar),
		.result,
		.result_valid,
		.result_group,
		.result_dst,
		.result_scalar,
		.wb_write,
		.wb_group,
		.wb_dst,
		.wb_dst_scalar,
		.wb_data
	);

endmodule

`default_nettype wire

//--- design/shader_writeback.sv
`timescale 1ns/1ps
`default_nettype none

module shader_writeback (
	input  logic                 clk,
	input  logic                 arst_n,
	input  shader_pkg::lane_word in_lanes,
	input  logic                 in_valid,
	input  shader_pkg::group_id  in_group,
	input  shader_pkg::reg_num   in_dst,
	input  logic                 in_dst_scalar,
	output shader_pkg::lane_word result,
	output logic                 result_valid,
	output shader_pkg::group_id  result_group,
	output shader_pkg::reg_num   result_dst,
	output logic                 result_scalar,
	output logic                 wb_write,
	output shader_pkg::group_id  wb_group,
	output shader_pkg::reg_num   wb_dst,
	output logic                 wb_dst_scalar,
	output shader_pkg::lane_word wb_data
);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			result_valid <= 1'b0;
		end else begin
			result_valid <= in_valid;
		end
	end

	always_ff @(posedge clk) begin
		result <= in_lanes;
		result_group <= in_group;
		result_dst <= in_dst;
		result_scalar <= in_dst_scalar;
	end

	// write pulse leaves with the result.
	assign wb_write = result_valid;
	assign wb_group = result_group;
	assign wb_dst = result_dst;
	assign wb_dst_scalar = result_scalar;
	assign wb_data = result; // sgpr takes lane 0.

endmodule

`default_nettype wire

//--- design/shader_alu.sv
`timescale 1ns/1ps
`default_nettype none

module shader_alu (
	input  logic                 clk,
	input  logic                 arst_n,
	input  shader_pkg::lane_word a_lanes,
	input  shader_pkg::lane_word b_lanes,
	input  logic                 in_valid,
	input  shader_pkg::opcode    in_code,
	input  shader_pkg::group_id  in_group,
	input  shader_pkg::reg_num   in_dst,
	input  logic                 in_dst_scalar,
	output shader_pkg::lane_word out_lanes,
	output logic                 out_valid,
	output shader_pkg::group_id  out_group,
	output shader_pkg::reg_num   out_dst,
	output logic                 out_dst_scalar
);

	shader_pkg::lane_word lanes_next;

	always_comb begin
		for (int i = 0; i < shader_pkg::LANES; i++) begin
			case (in_code)
				shader_pkg::OP_ADD:  lanes_next[i] = a_lanes[i] + b_lanes[i];
				shader_pkg::OP_SUB:  lanes_next[i] = a_lanes[i] - b_lanes[i];
				shader_pkg::OP_AND:  lanes_next[i] = a_lanes[i] & b_lanes[i];
				shader_pkg::OP_OR:   lanes_next[i] = a_lanes[i] | b_lanes[i];
				shader_pkg::OP_XOR:  lanes_next[i] = a_lanes[i] ^ b_lanes[i];
				shader_pkg::OP_MOV:  lanes_next[i] = b_lanes[i];
				shader_pkg::OP_LANE: lanes_next[i] = shader_pkg::word'(i);
				default:             lanes_next[i] = '0;
			endcase
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= in_valid;
		end
	end

	always_ff @(posedge clk) begin
		out_lanes <= lanes_next;
		out_group <= in_group;
		out_dst <= in_dst;
		out_dst_scalar <= in_dst_scalar;
	end

	code_known: assert property (@(posedge clk) disable iff (!arst_n)
		in_valid |-> !$isunknown(in_code));

endmodule

`default_nettype wire

//--- design/shader_operands.sv
`timescale 1ns/1ps
`default_nettype none

module shader_operands (
	input  logic                 clk,
	input  logic                 arst_n,
	shader_op_if.fetch           op_in,
	input  logic                 wb_write,
	input  shader_pkg::group_id  wb_group,
	input  shader_pkg::reg_num   wb_dst,
	input  logic                 wb_dst_scalar,
	input  shader_pkg::lane_word wb_data,
	output shader_pkg::lane_word a_lanes,
	output shader_pkg::lane_word b_lanes,
	output logic                 op_valid,
	output shader_pkg::opcode    op_code,
	output shader_pkg::group_id  op_group,
	output shader_pkg::reg_num   op_dst,
	output logic                 op_dst_scalar
);

	localparam int STAGES = shader_pkg::READ_STAGES + 2;
	localparam int NUM_BITS = $bits(shader_pkg::group_id) + $bits(shader_pkg::reg_num);

	shader_pkg::decoded_op op_pipe [STAGES];
	logic [STAGES-1:0] valid_pipe;
	shader_pkg::decoded_op sel_op;
	shader_pkg::decoded_op swap_op;
	shader_pkg::decoded_op out_op;

	shader_pkg::word sgpr_a_data;
	shader_pkg::word sgpr_b_data;
	shader_pkg::word vgpr_a_data [shader_pkg::LANES];
	shader_pkg::word vgpr_b_data [shader_pkg::LANES];

	shader_pkg::reg_num const_num;
	shader_pkg::word const_hold;
	shader_pkg::word const_data;

	shader_pkg::word b_word;
	shader_pkg::word scalar_a;
	shader_pkg::word scalar_b;
	logic b_broadcast;
	logic swap;

	assign sel_op = op_pipe[shader_pkg::READ_STAGES-1]; // read data lands here.
	assign swap_op = op_pipe[shader_pkg::READ_STAGES];
	assign out_op = op_pipe[STAGES-1];

	// ====================
	// register files
	shader_regfile #(.DEPTH_LOG(NUM_BITS)) sgprs (
		.clk,
		.read_a_num({op_pipe[0].group, op_pipe[0].a}), // one late, lines up with b select.
		.read_b_num({op_in.group, op_in.op.b}),
		.read_a_data(sgpr_a_data),
		.read_b_data(sgpr_b_data),
		.write(wb_write && wb_dst_scalar),
		.write_num({wb_group, wb_dst}),
		.write_data(wb_data[0])
	);

	for (genvar gi = 0; gi < shader_pkg::LANES; gi++) begin : vgprs
		shader_regfile #(.DEPTH_LOG(NUM_BITS)) file (
			.clk,
			.read_a_num({op_pipe[0].group, op_pipe[0].a}),
			.read_b_num({op_pipe[0].group, op_pipe[0].b}),
			.read_a_data(vgpr_a_data[gi]),
			.read_b_data(vgpr_b_data[gi]),
			.write(wb_write && !wb_dst_scalar),
			.write_num({wb_group, wb_dst}),
			.write_data(wb_data[gi])
		);
	end

	// ====================
	// op pipeline
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			valid_pipe <= '0;
		end else begin
			valid_pipe <= {valid_pipe[STAGES-2:0], op_in.valid};
		end
	end

	always_ff @(posedge clk) begin
		op_pipe[0] <= op_in.op;
		for (int i = 1; i < STAGES; i++)
			op_pipe[i] <= op_pipe[i-1];

		// constant rom, same depth as a regfile read.
		const_num <= op_in.op.b;
		const_hold <= shader_pkg::CONST_TABLE[const_num];
		const_data <= const_hold;
	end

	// ====================
	// b source, swap and lanes
	always_ff @(posedge clk) begin
		if (sel_op.b_is_imm)
			b_word <= sel_op.imm;
		else if (sel_op.b_is_const)
			b_word <= const_data;
		else
			b_word <= sgpr_b_data;
	end

	assign b_broadcast = swap_op.b_is_imm || swap_op.b_is_const || swap_op.b_scalar;
	assign swap = swap_op.scalar_rev && swap_op.a_scalar && b_broadcast;
	assign scalar_a = swap ? b_word : sgpr_a_data;
	assign scalar_b = swap ? sgpr_a_data : b_word;

	always_ff @(posedge clk) begin
		for (int i = 0; i < shader_pkg::LANES; i++) begin
			a_lanes[i] <= swap_op.a_scalar ? scalar_a : vgpr_a_data[i];
			b_lanes[i] <= b_broadcast ? scalar_b : vgpr_b_data[i];
		end
	end

	assign op_valid = valid_pipe[STAGES-1];
	assign op_code = out_op.opcode;
	assign op_group = out_op.group;
	assign op_dst = out_op.dst;
	assign op_dst_scalar = out_op.dst_scalar;

	valid_known: assert property (@(posedge clk) disable iff (!arst_n)
		!$isunknown(op_valid));

endmodule

`default_nettype wire

//--- design/shader_decode.sv
`timescale 1ns/1ps
`default_nettype none

module shader_decode (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  instr_valid,
	input  shader_pkg::instr_word instr,
	input  shader_pkg::group_id   group,
	shader_op_if.decode           op_out
);

	shader_pkg::decoded_op next_op;

	always_comb begin
		next_op = '0;
		if (instr.as_imm.imm_form) begin
			next_op.opcode = instr.as_imm.opcode;
			next_op.dst = instr.as_imm.dst;
			next_op.dst_scalar = instr.as_imm.dst_scalar;
			next_op.a = instr.as_imm.a;
			next_op.a_scalar = instr.as_imm.a_scalar;
			next_op.b_is_imm = 1'b1;
			next_op.imm = shader_pkg::word'(instr.as_imm.imm); // zero extended.
		end else begin
			next_op.opcode = instr.as_reg.opcode;
			next_op.dst = instr.as_reg.dst;
			next_op.dst_scalar = instr.as_reg.dst_scalar;
			next_op.a = instr.as_reg.a;
			next_op.a_scalar = instr.as_reg.a_scalar;
			next_op.b = instr.as_reg.b;
			next_op.b_scalar = instr.as_reg.b_scalar;
			next_op.b_is_const = instr.as_reg.b_is_const;
			next_op.scalar_rev = instr.as_reg.scalar_rev;
		end
		next_op.group = group;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			op_out.valid <= 1'b0;
		end else begin
			op_out.valid <= instr_valid;
		end
	end

	always_ff @(posedge clk) begin
		op_out.op <= next_op;
		op_out.group <= group;
	end

	// register form leaves the low bits clear.
	reserved_zero: assert property (@(posedge clk) disable iff (!arst_n)
		instr_valid && !instr.as_reg.imm_form |-> instr.as_reg.reserved == '0);

	opcode_range: assert property (@(posedge clk) disable iff (!arst_n)
		instr_valid |-> instr.as_reg.opcode <= shader_pkg::OP_LANE);

endmodule

`default_nettype wire

//--- design/shader_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module shader_regfile #(
	parameter int DEPTH_LOG = 6
) (
	input  logic                 clk,
	input  logic [DEPTH_LOG-1:0] read_a_num,
	input  logic [DEPTH_LOG-1:0] read_b_num,
	output shader_pkg::word      read_a_data,
	output shader_pkg::word      read_b_data,
	input  logic                 write,
	input  logic [DEPTH_LOG-1:0] write_num,
	input  shader_pkg::word      write_data
);

	localparam int DATA_STAGES = shader_pkg::READ_STAGES - 1; // after the address register.
	localparam int HOLD_STAGES = shader_pkg::WRITE_SETTLE - 1;

	shader_pkg::word file [1 << DEPTH_LOG];
	logic [DEPTH_LOG-1:0] a_num_q;
	logic [DEPTH_LOG-1:0] b_num_q;
	shader_pkg::word a_pipe [DATA_STAGES];
	shader_pkg::word b_pipe [DATA_STAGES];
	logic hold_write [HOLD_STAGES];
	logic [DEPTH_LOG-1:0] hold_num [HOLD_STAGES];
	shader_pkg::word hold_data [HOLD_STAGES];

	assign read_a_data = a_pipe[DATA_STAGES-1];
	assign read_b_data = b_pipe[DATA_STAGES-1];

	always_ff @(posedge clk) begin
		a_num_q <= read_a_num;
		b_num_q <= read_b_num;
		a_pipe[0] <= file[a_num_q];
		b_pipe[0] <= file[b_num_q];
		for (int i = 1; i < DATA_STAGES; i++) begin
			a_pipe[i] <= a_pipe[i-1];
			b_pipe[i] <= b_pipe[i-1];
		end

		hold_write[0] <= write;
		hold_num[0] <= write_num;
		hold_data[0] <= write_data;
		for (int i = 1; i < HOLD_STAGES; i++) begin
			hold_write[i] <= hold_write[i-1];
			hold_num[i] <= hold_num[i-1];
			hold_data[i] <= hold_data[i-1];
		end

		if (hold_write[HOLD_STAGES-1])
			file[hold_num[HOLD_STAGES-1]] <= hold_data[HOLD_STAGES-1];
	end

endmodule

`default_nettype wire

//--- design/shader_op_if.sv
`timescale 1ns/1ps
`default_nettype none

// decoded op, one cycle after the instruction strobe.
interface shader_op_if;

	logic                  valid;
	shader_pkg::decoded_op op;
	shader_pkg::group_id   group;

	modport decode (
		output valid,
		output op,
		output group
	);

	modport fetch (
		input valid,
		input op,
		input group
	);

endinterface

`default_nettype wire

//--- design/shader_pkg.sv
`default_nettype none

package shader_pkg;

	// ====================
	// sizes
	localparam int LANES = 4;
	localparam int WORD_BITS = 32;

	typedef logic [WORD_BITS-1:0] word;
	typedef logic [1:0] group_id;
	typedef logic [3:0] reg_num;
	typedef word [LANES-1:0] lane_word;

	typedef enum logic [2:0] {
		OP_ADD = 3'd0,
		OP_SUB,
		OP_AND,
		OP_OR,
		OP_XOR,
		OP_MOV,
		OP_LANE
	} opcode;

	// ====================
	// instruction formats
	typedef struct packed {
		logic       imm_form; // 0 here.
		opcode      opcode;
		logic       dst_scalar;
		reg_num     dst;
		logic       a_scalar;
		reg_num     a;
		logic       b_scalar;
		logic       b_is_const;
		logic       scalar_rev;
		reg_num     b;
		logic [10:0] reserved; // must be zero.
	} instr_reg;

	typedef struct packed {
		logic        imm_form; // 1 here.
		opcode       opcode;
		logic        dst_scalar;
		reg_num      dst;
		logic        a_scalar;
		reg_num      a;
		logic [1:0]  pad;
		logic [15:0] imm;
	} instr_imm;

	typedef union packed {
		instr_reg as_reg;
		instr_imm as_imm;
	} instr_word;

	typedef struct packed {
		opcode   opcode;
		group_id group;
		reg_num  dst;
		logic    dst_scalar;
		reg_num  a;
		logic    a_scalar;
		reg_num  b;
		logic    b_scalar;
		logic    b_is_imm;
		logic    b_is_const;
		logic    scalar_rev;
		word     imm;
	} decoded_op;

	// ====================
	// constants and timing
	localparam int CONST_ROM_ADDR_BITS = $bits(reg_num);

	localparam word CONST_TABLE [1 << CONST_ROM_ADDR_BITS] = '{
		0: 32'hffff_ffff,
		1: 32'h7fff_ffff,
		2: 32'h8000_0000,
		3: 32'h3f80_0000, // +1.0
		4: 32'hbf80_0000, // -1.0
		default: 32'h0
	};

	localparam int READ_STAGES = 3;
	localparam int PIPE_LATENCY = 8;
	localparam int WRITE_SETTLE = 2;

endpackage

`default_nettype wire
